// ==== verilog/gb_cfg.svh ====
// console system glue constants
// register addresses, memory region bounds, interrupt vectors
// and fake serial link timing

`ifndef GB_CFG_SVH
`define GB_CFG_SVH

// single address io registers
`define GB_ADDR_JOY   16'hFF00 // P1 joypad select
`define GB_ADDR_SB    16'hFF01 // serial data
`define GB_ADDR_SC    16'hFF02 // serial control
`define GB_ADDR_IF    16'hFF0F // interrupt flags
`define GB_ADDR_KEY1  16'hFF4D // speed switch, colour only
`define GB_ADDR_SVBK  16'hFF70 // wram bank, colour only
`define GB_ADDR_IE    16'hFFFF // interrupt enable

// memory regions, inclusive bounds
`define GB_WRAM_LO    16'hC000
`define GB_WRAM_HI    16'hFDFF // echo area folds onto wram
`define GB_ZP_LO      16'hFF80
`define GB_ZP_HI      16'hFFFE // 127 bytes

// interrupts
`define GB_IRQ_COUNT  5
`define GB_VEC_BASE   8'h40 // vblank vector
`define GB_VEC_STEP   8     // spacing between vectors
`define GB_VEC_IDLE   8'h55 // nothing pending

// internal clock serial
`define GB_SER_DIV    512 // cpu cycles per bit
`define GB_SER_BITS   8

// ram address widths
`define GB_WRAM_ABITS 15 // 8 banks of 4k
`define GB_ZP_ABITS   7

`endif

// ==== verilog/gb_bus_pkg.sv ====
// cpu bus types
// the flat bus the cpu core drives and the decoded region
// every glue block works from

package gb_bus_pkg;

	// one cycle of cpu bus, strobes active high
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        wr; // write lands on the edge ending this cycle
		logic        rd;
	} cpu_bus_t;

	// one region per address, picked by gb_addr_decode
	typedef enum logic [3:0] {
		rgn_none,  // rom, cart ram, unmapped
		rgn_wram,
		rgn_zpram,
		rgn_joy,
		rgn_sb,
		rgn_sc,
		rgn_iflag,
		rgn_ie,
		rgn_key1,
		rgn_svbk
	} gb_region_t;

endpackage

// ==== verilog/gb_irq_pkg.sv ====
// interrupt types
// source indices in priority order and the matching request vector

`include "gb_cfg.svh"

package gb_irq_pkg;

	// lowest index wins
	typedef enum logic [2:0] {
		irq_vblank = 3'd0,
		irq_lcd    = 3'd1,
		irq_timer  = 3'd2,
		irq_serial = 3'd3,
		irq_joypad = 3'd4
	} irq_src_t;

	// one bit per source, indexed by irq_src_t
	typedef logic [`GB_IRQ_COUNT-1:0] irq_vec_t;

endpackage

// ==== verilog/gb_addr_decode.sv ====
// cpu address decoder
// maps each bus address onto exactly one region, colour-only
// registers drop to none on the original console

`timescale 1ns/1ps

`include "gb_cfg.svh"

module gb_addr_decode (
	input  gb_bus_pkg::cpu_bus_t   cpu_bus,
	input  logic                   is_gbc,
	output gb_bus_pkg::gb_region_t region
);

	import gb_bus_pkg::*;

	logic [15:0] addr;
	logic        in_wram;
	logic        in_zp;

	assign addr = cpu_bus.addr;

	// c000-fdff incl echo
	assign in_wram = (addr >= `GB_WRAM_LO) && (addr <= `GB_WRAM_HI);
	// ff80-fffe, ffff is ie
	assign in_zp   = (addr >= `GB_ZP_LO) && (addr <= `GB_ZP_HI);

	//----------------------------------------------------------------------
	// region select
	//----------------------------------------------------------------------
	always_comb begin
		region = rgn_none; // rom, cart ram, unused io
		if (in_wram) begin
			region = rgn_wram;
		end else if (in_zp) begin
			region = rgn_zpram;
		end else begin
			case (addr)
				`GB_ADDR_JOY:  region = rgn_joy;
				`GB_ADDR_SB:   region = rgn_sb;
				`GB_ADDR_SC:   region = rgn_sc;
				`GB_ADDR_IF:   region = rgn_iflag;
				`GB_ADDR_IE:   region = rgn_ie;
				`GB_ADDR_KEY1: region = is_gbc ? rgn_key1 : rgn_none; // colour only
				`GB_ADDR_SVBK: region = is_gbc ? rgn_svbk : rgn_none;
				default:       region = rgn_none;
			endcase
		end
	end

endmodule

// ==== verilog/gb_wram.sv ====
// work ram and zero page ram
// 8k of work ram, 32k in colour mode with the upper 4k window
// banked through SVBK, plus 127 bytes of zero page

`timescale 1ns/1ps

`include "gb_cfg.svh"

module gb_wram (
	input  logic                   clk_cpu,
	input  logic                   reset,
	input  gb_bus_pkg::cpu_bus_t   cpu_bus,
	input  gb_bus_pkg::gb_region_t region,
	input  logic                   is_gbc,
	output logic [7:0]             rdata
);

	import gb_bus_pkg::*;

	logic [7:0] wram_mem [0:(1 << `GB_WRAM_ABITS)-1];
	logic [7:0] zp_mem   [0:(1 << `GB_ZP_ABITS)-2]; // 127 bytes

	logic [2:0]                  svbk_bank; // 1..7
	logic [2:0]                  bank_eff;
	logic [`GB_WRAM_ABITS-1:0]   wram_addr;
	logic [`GB_ZP_ABITS-1:0]     zp_addr;

	// original console has bank 1 fixed at d000
	assign bank_eff  = is_gbc ? svbk_bank : 3'd1;
	// d000-dfff window follows the bank, c000-cfff is always bank 0
	assign wram_addr = cpu_bus.addr[12] ? {bank_eff, cpu_bus.addr[11:0]}
	                                    : {3'd0, cpu_bus.addr[11:0]};
	assign zp_addr   = cpu_bus.addr[`GB_ZP_ABITS-1:0];

	// SVBK bank register
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			svbk_bank <= 3'd1;
		end else if (cpu_bus.wr && region == rgn_svbk) begin
			// bank 0 maps to 1
			svbk_bank <= (cpu_bus.wdata[2:0] == 3'd0) ? 3'd1 : cpu_bus.wdata[2:0];
		end
	end

	//----------------------------------------------------------------------
	// arrays, sync write and registered read
	//----------------------------------------------------------------------
	always_ff @(posedge clk_cpu) begin
		if (cpu_bus.wr && region == rgn_wram)
			wram_mem[wram_addr] <= cpu_bus.wdata;
		if (cpu_bus.wr && region == rgn_zpram)
			zp_mem[zp_addr] <= cpu_bus.wdata;
		if (cpu_bus.rd) begin
			case (region)
				rgn_zpram: rdata <= zp_mem[zp_addr];
				rgn_svbk:  rdata <= {5'b11111, svbk_bank};
				default:   rdata <= wram_mem[wram_addr]; // old data on same-cycle write
			endcase
		end
	end

endmodule

// ==== verilog/gb_io_regs.sv ====
// joypad, speed switch and serial registers
// P1 select lines and button matrix, KEY1 prepare and speed bits,
// and the internal clock serial transfer with no link partner
// so SB always reads back as ff

`timescale 1ns/1ps

`include "gb_cfg.svh"

module gb_io_regs (
	input  logic                   clk_cpu,
	input  logic                   reset,
	input  gb_bus_pkg::cpu_bus_t   cpu_bus,
	input  gb_bus_pkg::gb_region_t region,
	input  logic                   is_gbc,
	input  logic                   cpu_stop,  // stop instruction pulse
	input  logic [7:0]             joystick,  // active high buttons
	input  logic [5:0]             joy_sgb,
	output logic [5:0]             joy_p54,
	output logic [7:0]             joy_lines,
	output logic                   serial_irq,
	output logic                   sc_int_clock,
	output logic                   speed,
	output logic [7:0]             rdata
);

	import gb_bus_pkg::*;

	localparam int ser_div_bits = $clog2(`GB_SER_DIV);
	localparam int ser_cnt_bits = $clog2(`GB_SER_BITS + 1);

	logic [1:0]              p54;       // P15 P14 select, low selects
	logic [3:0]              joy_p4;
	logic [3:0]              joy_p5;
	logic                    prepare;
	logic                    sc_start;
	logic                    sc_wr;
	logic                    ser_run;
	logic                    ser_done;
	logic [ser_div_bits-1:0] ser_div;   // cycles left in the bit
	logic [ser_cnt_bits-1:0] ser_cnt;   // bits left

	//----------------------------------------------------------------------
	// joypad
	//----------------------------------------------------------------------
	// directions on P14, buttons on P15, deselected nibble reads high
	assign joy_p4    = ~{joystick[2], joystick[3], joystick[1], joystick[0]} | {4{p54[0]}};
	assign joy_p5    = ~{joystick[7], joystick[6], joystick[5], joystick[4]} | {4{p54[1]}};
	assign joy_lines = {joy_p4, joy_p5};
	assign joy_p54   = {p54, joy_p4 & joy_p5};

	// p54 select and KEY1 state
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			p54     <= 2'b11;
			prepare <= 1'b0;
			speed   <= 1'b0;
		end else begin
			if (cpu_bus.wr && region == rgn_joy)
				p54 <= cpu_bus.wdata[5:4];
			if (cpu_bus.wr && region == rgn_key1)
				prepare <= cpu_bus.wdata[0];
			if (is_gbc && prepare && cpu_stop) begin // switch on stop
				speed   <= ~speed;
				prepare <= 1'b0;
			end
		end
	end

	//----------------------------------------------------------------------
	// fake serial, internal clock only
	//----------------------------------------------------------------------
	assign sc_wr    = cpu_bus.wr && region == rgn_sc;
	assign ser_run  = sc_start && sc_int_clock && !sc_wr;
	assign ser_done = ser_run && ser_cnt == '0;

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			sc_start     <= 1'b0;
			sc_int_clock <= 1'b0;
			serial_irq   <= 1'b0;
		end else begin
			serial_irq <= ser_done; // one cycle pulse
			if (sc_wr) begin
				sc_start     <= cpu_bus.wdata[7];
				sc_int_clock <= cpu_bus.wdata[0];
			end else if (ser_done) begin
				sc_start <= 1'b0; // transfer over
			end
		end
	end

	// bit divider and countdown
	always_ff @(posedge clk_cpu) begin
		if ((sc_wr && cpu_bus.wdata[7]) || ser_done) begin
			ser_div <= ser_div_bits'(`GB_SER_DIV - 1);
			ser_cnt <= ser_cnt_bits'(`GB_SER_BITS);
		end else if (ser_run) begin
			ser_div <= ser_div - 1'b1;
			if (ser_div == '0)
				ser_cnt <= ser_cnt - 1'b1; // next bit
		end
	end

	always_comb begin
		case (region)
			rgn_joy:  rdata = {2'b11, joy_sgb};
			rgn_sb:   rdata = 8'hFF; // nothing shifted in
			rgn_sc:   rdata = {sc_start, 6'h3F, sc_int_clock};
			rgn_key1: rdata = {speed, 6'h3F, prepare};
			default:  rdata = 8'hFF;
		endcase
	end

endmodule

// ==== verilog/gb_irq_ctrl.sv ====
// interrupt controller
// IE and IF registers, the priority vector for the acknowledge cycle,
// clearing of the served flag when acknowledge drops and
// the joypad falling edge source

`timescale 1ns/1ps

`include "gb_cfg.svh"

module gb_irq_ctrl (
	input  logic                   clk_cpu,
	input  logic                   reset,
	input  gb_bus_pkg::cpu_bus_t   cpu_bus,
	input  gb_bus_pkg::gb_region_t region,
	input  logic                   irq_ack,
	input  gb_irq_pkg::irq_vec_t   src_pulse, // one cycle pulses
	input  logic [7:0]             joy_lines, // active low button lines
	output logic                   irq_n,
	output logic [7:0]             irq_vector,
	output logic [7:0]             rdata
);

	import gb_bus_pkg::*;
	import gb_irq_pkg::*;

	irq_vec_t   if_r;
	irq_vec_t   ie_r;
	irq_vec_t   pending;
	irq_vec_t   set_vec;
	irq_src_t   top_src;    // highest priority pending source
	logic       top_valid;
	logic [7:0] joy_d1;
	logic [7:0] joy_d2;
	logic       joy_edge;   // registered falling edge on any line
	logic       ack_q;
	logic       ack_fall;

	assign pending  = if_r & ie_r;
	assign irq_n    = ~|pending; // low while anything is flagged and enabled
	assign ack_fall = ack_q & ~irq_ack;

	// joypad edge joins the external pulses on its own bit
	always_comb begin
		set_vec = src_pulse;
		set_vec[irq_joypad] = set_vec[irq_joypad] | joy_edge;
	end

	// priority encoder, lowest index wins
	always_comb begin
		top_valid = 1'b0;
		top_src   = irq_vblank;
		for (int i = `GB_IRQ_COUNT-1; i >= 0; i--) begin
			if (pending[i]) begin
				top_valid = 1'b1;
				top_src   = irq_src_t'(i);
			end
		end
	end

	assign irq_vector = top_valid ? `GB_VEC_BASE + 8'(`GB_VEC_STEP) * 8'(top_src)
	                              : `GB_VEC_IDLE;

	//----------------------------------------------------------------------
	// flag and enable registers
	//----------------------------------------------------------------------
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			if_r     <= '0;
			ie_r     <= '0;
			ack_q    <= 1'b0;
			joy_d1   <= 8'hFF; // all released
			joy_d2   <= 8'hFF;
			joy_edge <= 1'b0;
		end else begin
			ack_q    <= irq_ack;
			joy_d1   <= joy_lines;
			joy_d2   <= joy_d1;
			joy_edge <= |(~joy_d1 & joy_d2);
			if_r     <= if_r | set_vec;
			if (ack_fall && top_valid)
				if_r[top_src] <= 1'b0; // served source only
			if (cpu_bus.wr && region == rgn_iflag)
				if_r <= cpu_bus.wdata[`GB_IRQ_COUNT-1:0]; // cpu write wins
			if (cpu_bus.wr && region == rgn_ie)
				ie_r <= cpu_bus.wdata[`GB_IRQ_COUNT-1:0];
		end
	end

	// register readback, unused upper bits differ between IF and IE
	always_comb begin
		case (region)
			rgn_iflag: rdata = {3'b111, if_r};
			rgn_ie:    rdata = {3'b000, ie_r};
			default:   rdata = 8'hFF;
		endcase
	end

endmodule

// ==== verilog/gb_sys.sv ====
// console system glue top
// decodes the cpu bus, hosts work ram, io and interrupt blocks
// and returns registered read data or the interrupt vector

`timescale 1ns/1ps

module gb_sys (
	input  logic                 clk_cpu,
	input  logic                 reset,
	input  gb_bus_pkg::cpu_bus_t cpu_bus,
	input  logic                 is_gbc,
	input  logic                 irq_ack,
	input  logic                 cpu_stop,
	input  logic                 vblank_irq,
	input  logic                 lcd_irq,
	input  logic                 timer_irq,
	input  logic [7:0]           joystick,
	input  logic [5:0]           joy_sgb,
	output logic [7:0]           cpu_rdata,
	output logic                 irq_n,
	output logic                 speed,
	output logic [5:0]           joy_p54,
	output logic                 sc_int_clock
);

	import gb_bus_pkg::*;
	import gb_irq_pkg::*;

	gb_region_t region;
	irq_vec_t   src_pulse;
	logic [7:0] wram_rdata;   // already registered in the ram
	logic [7:0] io_rdata;
	logic [7:0] irq_rdata;
	logic [7:0] irq_vector;
	logic [7:0] joy_lines;
	logic       serial_irq;
	logic [7:0] rdata_q;
	logic       use_ram_q;    // last cycle addressed ram or SVBK

	// joypad source is added inside the interrupt block
	always_comb begin
		src_pulse             = '0;
		src_pulse[irq_vblank] = vblank_irq;
		src_pulse[irq_lcd]    = lcd_irq;
		src_pulse[irq_timer]  = timer_irq;
		src_pulse[irq_serial] = serial_irq;
	end

	gb_addr_decode u_decode (.cpu_bus(cpu_bus), .is_gbc(is_gbc), .region(region));

	gb_wram u_wram (
		.clk_cpu(clk_cpu), .reset(reset), .cpu_bus(cpu_bus), .region(region),
		.is_gbc(is_gbc), .rdata(wram_rdata)
	);

	gb_io_regs u_io (
		.clk_cpu(clk_cpu), .reset(reset), .cpu_bus(cpu_bus), .region(region),
		.is_gbc(is_gbc), .cpu_stop(cpu_stop), .joystick(joystick), .joy_sgb(joy_sgb),
		.joy_p54(joy_p54), .joy_lines(joy_lines), .serial_irq(serial_irq),
		.sc_int_clock(sc_int_clock), .speed(speed), .rdata(io_rdata)
	);

	gb_irq_ctrl u_irq (
		.clk_cpu(clk_cpu), .reset(reset), .cpu_bus(cpu_bus), .region(region),
		.irq_ack(irq_ack), .src_pulse(src_pulse), .joy_lines(joy_lines),
		.irq_n(irq_n), .irq_vector(irq_vector), .rdata(irq_rdata)
	);

	//----------------------------------------------------------------------
	// read mux, vector first during acknowledge
	//----------------------------------------------------------------------
	always_ff @(posedge clk_cpu) begin
		if (reset)
			use_ram_q <= 1'b0;
		else
			use_ram_q <= !irq_ack && (region inside {rgn_wram, rgn_zpram, rgn_svbk});
		if (irq_ack) begin
			rdata_q <= irq_vector;
		end else begin
			case (region)
				rgn_joy, rgn_sb, rgn_sc, rgn_key1: rdata_q <= io_rdata;
				rgn_iflag, rgn_ie:                 rdata_q <= irq_rdata;
				default:                           rdata_q <= 8'hFF; // rom, cart, unmapped
			endcase
		end
	end

	assign cpu_rdata = use_ram_q ? wram_rdata : rdata_q;

endmodule

// ==== testbench/tb_clock.sv ====
// clock and reset source for the console glue testbench
// 40 ns cpu clock, reset held over the first four rising edges

`timescale 1ns/1ps

module tb_clock (
	output logic clk_cpu,
	output logic reset
);

	initial begin
		clk_cpu = 1'b0;
		forever #20 clk_cpu = ~clk_cpu; // 25 MHz
	end

	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clk_cpu);
		@(negedge clk_cpu); // drop with the other stimulus
		reset = 1'b0;
	end

endmodule

// ==== testbench/tb_checker.sv ====
// read checker for the console glue
// keeps a reference copy of work ram, zero page and SVBK built from
// the bus writes, and compares cpu_rdata one cycle after each read

`timescale 1ns/1ps

`include "gb_cfg.svh"

module tb_checker (
	input  logic                 clk_cpu,
	input  logic                 reset,
	input  gb_bus_pkg::cpu_bus_t cpu_bus,
	input  logic                 is_gbc,
	input  logic                 irq_ack,
	input  logic [7:0]           cpu_rdata,
	input  logic                 irq_n,
	input  logic                 speed,
	input  logic [5:0]           joy_p54,
	input  logic                 sc_int_clock,
	input  logic                 exp_ovr,  // test supplies the value
	input  logic [7:0]           exp_data,
	input  logic                 side_chk, // compare the pins this cycle
	input  logic [8:0]           side_exp, // sc_int_clock, irq_n, speed, joy_p54
	output int                   err_count,
	output int                   chk_count
);

	logic [7:0]  wram_ref [0:(1 << `GB_WRAM_ABITS)-1];
	bit          wram_set [0:(1 << `GB_WRAM_ABITS)-1]; // byte was written
	logic [7:0]  zp_ref   [0:126];
	bit          zp_set   [0:126];
	logic [2:0]  svbk_ref;
	logic        pend_valid = 1'b0; // a read waits for its data
	logic [7:0]  pend_exp;
	logic [15:0] pend_addr;
	int          errs = 0;
	int          chks = 0;

	assign err_count = errs;
	assign chk_count = chks;

	// c000-cfff bank 0, d000-dfff the selected bank, fixed 1 on mono
	function automatic logic [14:0] wram_index(input logic [15:0] a);
		logic [2:0] bank;
		bank = a[12] ? (is_gbc ? svbk_ref : 3'd1) : 3'd0;
		return {bank, a[11:0]};
	endfunction

	// expected read data with a known flag in the top bit
	function automatic logic [8:0] model_read(input logic [15:0] a);
		logic [14:0] idx;
		idx = wram_index(a);
		if (a >= `GB_WRAM_LO && a <= `GB_WRAM_HI)
			return {wram_set[idx], wram_ref[idx]};
		if (a >= `GB_ZP_LO && a <= `GB_ZP_HI)
			return {zp_set[a[6:0]], zp_ref[a[6:0]]};
		if (a == `GB_ADDR_SVBK && is_gbc)
			return {1'b1, 5'b11111, svbk_ref};
		if (a == `GB_ADDR_KEY1 && is_gbc)
			return 9'h000; // the test supplies it
		if (a inside {`GB_ADDR_JOY, `GB_ADDR_SC, `GB_ADDR_IF, `GB_ADDR_IE})
			return 9'h000;
		return {1'b1, 8'hFF}; // SB, rom, cart ram, unused io
	endfunction

	task automatic apply_write(input logic [15:0] a, input logic [7:0] d);
		logic [14:0] idx;
		idx = wram_index(a);
		if (a >= `GB_WRAM_LO && a <= `GB_WRAM_HI) begin
			wram_ref[idx] = d;
			wram_set[idx] = 1'b1;
		end else if (a >= `GB_ZP_LO && a <= `GB_ZP_HI) begin
			zp_ref[a[6:0]] = d;
			zp_set[a[6:0]] = 1'b1;
		end else if (a == `GB_ADDR_SVBK && is_gbc) begin
			svbk_ref = (d[2:0] == 3'd0) ? 3'd1 : d[2:0]; // bank 0 gives 1
		end
	endtask

	task automatic compare_value(input string name, input logic [7:0] got,
	                             input logic [7:0] exp);
		chks++;
		if (got !== exp) begin
			errs++;
			$display("[FAIL] %0d ns %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	//----------------------------------------------------------------------
	// compare, then sample the new cycle, then apply its write
	//----------------------------------------------------------------------
	always @(posedge clk_cpu) begin
		logic [8:0] m;
		if (reset) begin
			svbk_ref   = 3'd1;
			pend_valid = 1'b0;
		end else begin
			if (pend_valid) // data registered at the previous edge
				compare_value($sformatf("cpu_rdata at %h", pend_addr), cpu_rdata, pend_exp);
			pend_valid = 1'b0;
			if (side_chk) begin
				compare_value("sc_int_clock", {7'd0, sc_int_clock}, {7'd0, side_exp[8]});
				compare_value("irq_n", {7'd0, irq_n}, {7'd0, side_exp[7]});
				compare_value("speed", {7'd0, speed}, {7'd0, side_exp[6]});
				compare_value("joy_p54", {2'd0, joy_p54}, {2'd0, side_exp[5:0]});
			end
			m = model_read(cpu_bus.addr);
			pend_addr = cpu_bus.addr;
			if (exp_ovr && (cpu_bus.rd || irq_ack)) begin
				pend_exp   = exp_data;
				pend_valid = 1'b1;
			end else if (cpu_bus.rd && !irq_ack && m[8]) begin
				pend_exp   = m[7:0];
				pend_valid = 1'b1;
			end
			if (cpu_bus.wr)
				apply_write(cpu_bus.addr, cpu_bus.wdata);
		end
	end

endmodule

// ==== testbench/tb_gb_sys.sv ====
// console glue testbench top
// drives the cpu bus on falling edges and steps through ram, interrupt,
// joypad, serial, speed switch and unmapped address tests

`timescale 1ns/1ps

`include "gb_cfg.svh"

module tb_gb_sys;

	import gb_bus_pkg::*;

	logic        clk_cpu;
	logic        reset;
	cpu_bus_t    cpu_bus;
	logic        is_gbc;
	logic        irq_ack;
	logic        cpu_stop;
	logic        vblank_irq;
	logic        lcd_irq;
	logic        timer_irq;
	logic [7:0]  joystick;
	logic [5:0]  joy_sgb;
	logic [7:0]  cpu_rdata;
	logic        irq_n;
	logic        speed;
	logic [5:0]  joy_p54;
	logic        sc_int_clock;
	logic        exp_ovr;
	logic [7:0]  exp_data;
	logic        side_chk;
	logic [8:0]  side_exp;
	int          err_count;
	int          chk_count;
	int          tmo_count;
	int          base_err;
	int          base_chk;
	int          base_tmo;
	integer      seed;
	logic [11:0] bank_off [4]; // same offsets in every bank
	logic [15:0] plain_q [$];  // unbanked ram addresses written

	tb_clock clk0 (.clk_cpu(clk_cpu), .reset(reset));

	gb_sys dut0 (
		.clk_cpu(clk_cpu), .reset(reset), .cpu_bus(cpu_bus), .is_gbc(is_gbc),
		.irq_ack(irq_ack), .cpu_stop(cpu_stop), .vblank_irq(vblank_irq),
		.lcd_irq(lcd_irq), .timer_irq(timer_irq), .joystick(joystick),
		.joy_sgb(joy_sgb), .cpu_rdata(cpu_rdata), .irq_n(irq_n), .speed(speed),
		.joy_p54(joy_p54), .sc_int_clock(sc_int_clock)
	);

	tb_checker chk0 (
		.clk_cpu(clk_cpu), .reset(reset), .cpu_bus(cpu_bus), .is_gbc(is_gbc),
		.irq_ack(irq_ack), .cpu_rdata(cpu_rdata), .irq_n(irq_n), .speed(speed),
		.joy_p54(joy_p54), .sc_int_clock(sc_int_clock), .exp_ovr(exp_ovr),
		.exp_data(exp_data), .side_chk(side_chk), .side_exp(side_exp),
		.err_count(err_count), .chk_count(chk_count)
	);

	task automatic write_reg(input logic [15:0] a, input logic [7:0] d);
		cpu_bus = {a, d, 1'b1, 1'b0};
		@(negedge clk_cpu);
		cpu_bus = '0;
	endtask

	// checker takes the value from its model
	task automatic read_model(input logic [15:0] a);
		cpu_bus = {a, 8'h00, 1'b0, 1'b1};
		@(negedge clk_cpu);
		cpu_bus = '0;
	endtask

	task automatic read_expect(input logic [15:0] a, input logic [7:0] d);
		cpu_bus  = {a, 8'h00, 1'b0, 1'b1};
		exp_ovr  = 1'b1;
		exp_data = d;
		@(negedge clk_cpu);
		cpu_bus = '0;
		exp_ovr = 1'b0;
	endtask

	// one acknowledge cycle, then the cycle where the flag clears
	task automatic ack_expect(input logic [7:0] vec);
		irq_ack  = 1'b1;
		exp_ovr  = 1'b1;
		exp_data = vec;
		@(negedge clk_cpu);
		irq_ack = 1'b0;
		exp_ovr = 1'b0;
		@(negedge clk_cpu);
	endtask

	task automatic check_pins(input logic n, input logic s, input logic [5:0] p,
	                          input logic c);
		side_chk = 1'b1;
		side_exp = {c, n, s, p};
		@(negedge clk_cpu);
		side_chk = 1'b0;
	endtask

	task automatic pulse_line(input int which);
		case (which)
			0:       vblank_irq = 1'b1;
			1:       lcd_irq    = 1'b1;
			2:       timer_irq  = 1'b1;
			default: cpu_stop   = 1'b1;
		endcase
		@(negedge clk_cpu);
		{vblank_irq, lcd_irq, timer_irq, cpu_stop} = 4'b0000;
	endtask

	task automatic finish_test(input string name);
		repeat (2) @(negedge clk_cpu); // last read still in flight
		$display("%-8s %0d checks, %0d errors", name, chk_count - base_chk,
		         err_count - base_err + tmo_count - base_tmo);
		base_err = err_count;
		base_chk = chk_count;
		base_tmo = tmo_count;
	endtask

	initial begin
		int n;
		seed     = 32'h6725_a7f7;
		cpu_bus  = '0;
		{is_gbc, irq_ack, cpu_stop, vblank_irq, lcd_irq, timer_irq} = 6'b100000;
		joystick = 8'h00;
		joy_sgb  = 6'h2F;
		{exp_ovr, exp_data, side_chk, side_exp} = '0;
		{tmo_count, base_err, base_chk, base_tmo} = '0;

		for (n = 0; n < 20 && reset !== 1'b0; n++)
			@(negedge clk_cpu);
		if (reset !== 1'b0) begin
			tmo_count++;
			$display("timeout: reset was never released");
		end

		// ------------------------------------------------------------------
		// 1 work ram, zero page and SVBK banking
		for (int k = 0; k < 4; k++)
			bank_off[k] = 12'($random(seed));
		for (int b = 0; b < 8; b++) begin
			write_reg(`GB_ADDR_SVBK, 8'(b)); // 0 lands in bank 1
			read_model(`GB_ADDR_SVBK);
			for (int k = 0; k < 4; k++) begin
				write_reg({4'hD, bank_off[k]}, 8'($random(seed)));
				plain_q.push_back({4'hC, 12'($random(seed))});
				write_reg(plain_q[$], 8'($random(seed)));
			end
			n = $unsigned($random(seed)) % 127;
			plain_q.push_back(16'hFF80 + 16'(n));
			write_reg(plain_q[$], 8'($random(seed)));
		end
		for (int b = 1; b < 8; b++) begin
			write_reg(`GB_ADDR_SVBK, 8'(b));
			for (int k = 0; k < 4; k++)
				read_model({4'hD, bank_off[k]});
		end
		foreach (plain_q[i])
			read_model(plain_q[i]);
		read_model(plain_q[0] + 16'h2000); // echo area
		is_gbc = 1'b0; // mono with bank 1 fixed
		write_reg(`GB_ADDR_SVBK, 8'h05);
		read_model(`GB_ADDR_SVBK);
		for (int k = 0; k < 4; k++)
			read_model({4'hD, bank_off[k]});
		is_gbc = 1'b1;
		finish_test("wram");

		// ------------------------------------------------------------------
		// 2 IE and IF, vectors and acknowledge
		pulse_line(0);
		pulse_line(1);
		pulse_line(2);
		read_expect(`GB_ADDR_IF, 8'hE7);
		check_pins(1'b1, 1'b0, 6'h3F, 1'b0); // nothing enabled
		write_reg(`GB_ADDR_IE, 8'h05); // vblank and timer
		read_expect(`GB_ADDR_IE, 8'h05);
		check_pins(1'b0, 1'b0, 6'h3F, 1'b0);
		ack_expect(8'h40); // vblank wins
		read_expect(`GB_ADDR_IF, 8'hE6);
		ack_expect(8'h50); // timer next while lcd stays masked
		read_expect(`GB_ADDR_IF, 8'hE2);
		check_pins(1'b1, 1'b0, 6'h3F, 1'b0);
		ack_expect(`GB_VEC_IDLE);
		read_expect(`GB_ADDR_IF, 8'hE2);
		write_reg(`GB_ADDR_IF, 8'h00);
		write_reg(`GB_ADDR_IE, 8'h00);
		finish_test("irq");

		// ------------------------------------------------------------------
		// 3 joypad select and falling edge
		read_expect(`GB_ADDR_JOY, 8'hEF);
		write_reg(`GB_ADDR_JOY, 8'h20); // directions
		joystick = 8'h10; // button group is deselected
		check_pins(1'b1, 1'b0, 6'h2F, 1'b0); // no direction line low
		joystick = 8'h01;
		check_pins(1'b1, 1'b0, 6'h2E, 1'b0); // direction line 0 low
		repeat (3) @(negedge clk_cpu);
		write_reg(`GB_ADDR_IF, 8'h00);
		joystick = 8'h00; // release gives rising lines
		repeat (3) @(negedge clk_cpu);
		read_expect(`GB_ADDR_IF, 8'hE0);
		joystick = 8'h01;
		repeat (3) @(negedge clk_cpu); // sampled, edge, flag
		read_expect(`GB_ADDR_IF, 8'hF0);
		finish_test("joypad");

		// ------------------------------------------------------------------
		// 4 internal clock serial with no partner
		write_reg(`GB_ADDR_IF, 8'h00);
		write_reg(`GB_ADDR_SC, 8'h81);
		read_expect(`GB_ADDR_SC, 8'hFF);
		cpu_bus = {`GB_ADDR_SC, 8'h00, 1'b0, 1'b1}; // poll SC
		@(negedge clk_cpu);
		for (n = 0; n < 5000 && cpu_rdata[7]; n++)
			@(negedge clk_cpu);
		cpu_bus = '0;
		if (cpu_rdata[7]) begin
			tmo_count++;
			$display("timeout: SC start bit never cleared after the serial transfer");
		end
		read_expect(`GB_ADDR_IF, 8'hE8);
		read_model(`GB_ADDR_SB);
		read_expect(`GB_ADDR_SC, 8'h7F);
		check_pins(1'b1, 1'b0, 6'h2E, 1'b1); // internal clock kept
		finish_test("serial");

		// ------------------------------------------------------------------
		// 5 KEY1 speed switch
		read_expect(`GB_ADDR_KEY1, 8'h7E);
		write_reg(`GB_ADDR_KEY1, 8'h01);
		read_expect(`GB_ADDR_KEY1, 8'h7F);
		pulse_line(3);
		read_expect(`GB_ADDR_KEY1, 8'hFE); // fast with prepare cleared
		check_pins(1'b1, 1'b1, 6'h2E, 1'b1);
		write_reg(`GB_ADDR_KEY1, 8'h01);
		is_gbc = 1'b0; // stop is ignored on mono
		read_model(`GB_ADDR_KEY1);
		pulse_line(3);
		check_pins(1'b1, 1'b1, 6'h2E, 1'b1);
		is_gbc = 1'b1;
		read_expect(`GB_ADDR_KEY1, 8'hFF);
		pulse_line(3);
		read_expect(`GB_ADDR_KEY1, 8'h7E); // back to normal
		finish_test("key1");

		// ------------------------------------------------------------------
		// 6 rom, cart ram and unused io
		read_model(16'h0150);
		read_model(16'hA000);
		read_model(16'hFF50);
		read_model(16'hFEA0);
		finish_test("unmapped");

		$display("total %0d checks, %0d errors, %0d timeouts", chk_count, err_count, tmo_count);
		if (err_count == 0 && tmo_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+verilog
verilog/gb_bus_pkg.sv
verilog/gb_irq_pkg.sv
verilog/gb_addr_decode.sv
verilog/gb_wram.sv
verilog/gb_io_regs.sv
verilog/gb_irq_ctrl.sv
verilog/gb_sys.sv
testbench/tb_clock.sv
testbench/tb_checker.sv
testbench/tb_gb_sys.sv

// ==== Makefile ====
TOP = tb_gb_sys

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f filelist.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
